//--- exec_core.f
+incdir+source
source/cpu_pkg.sv
source/instr_decode.sv
source/alu.sv
source/reg_file.sv
source/execute.sv
source/exec_core.sv
tb/exec_core_checker.sv
tb/exec_core_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f exec_core.f --top-module exec_core_tb -o sim
	./obj_dir/sim | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/exec_core_tb.sv
`include "cpu_macros.svh"

module exec_core_tb import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_ROWS = 64;

    logic     clk = 1'b0;
    logic     rst;
    word_t    instr;
    word_t    imm;
    logic     submit;
    logic     jmp_predict;
    logic     ready;
    logic     flush;
    word_t    pc;
    logic     wb_valid;
    reg_idx_t wb_reg;
    word_t    wb_data;

    // Stimulus and expected results
    word_t    t_instr[MAX_ROWS];
    word_t    t_imm[MAX_ROWS];
    logic     t_pred[MAX_ROWS];
    int       t_kind[MAX_ROWS];
    reg_idx_t t_reg[MAX_ROWS];
    word_t    t_data[MAX_ROWS];
    word_t    t_pc[MAX_ROWS];
    logic     t_flush[MAX_ROWS];
    int       t_hold[MAX_ROWS];
    int       holds[MAX_ROWS];
    int       n_rows = 0;
    int       seed = 32'h8a68;

    always #20 clk = ~clk;

    exec_core uut (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_instr       (instr),
        .i_imm         (imm),
        .i_submit      (submit),
        .i_jmp_predict (jmp_predict),
        .o_ready       (ready),
        .o_flush       (flush),
        .o_pc          (pc),
        .o_wb_valid    (wb_valid),
        .o_wb_reg      (wb_reg),
        .o_wb_data     (wb_data)
    );

    exec_core_checker chk (
        .i_clk      (clk),
        .i_flush    (flush),
        .i_pc       (pc),
        .i_wb_valid (wb_valid),
        .i_wb_reg   (wb_reg),
        .i_wb_data  (wb_data)
    );

    function automatic word_t enc_alu(input logic [3:0] op, input reg_idx_t d,
                                      input reg_idx_t l, input reg_idx_t r, input alu_mode_t m);
        return {op, d, l, r, m};
    endfunction

    function automatic word_t enc_jump(input reg_idx_t l, input logic [3:0] cond);
        return {`OP_JMP, 3'd0, l, 2'b00, cond};
    endfunction

    // Condition table of the ten jump codes
    function automatic logic cond_ref(input logic [3:0] c, input flags_t f);
        case (c)
            4'd0:    return 1'b1;
            4'd1:    return f[`FLAG_C];
            4'd2:    return f[`FLAG_Z];
            4'd3:    return f[`FLAG_N];
            4'd4:    return !f[`FLAG_N] && !f[`FLAG_Z];
            4'd5:    return f[`FLAG_N] || f[`FLAG_Z];
            4'd6:    return !f[`FLAG_N];
            4'd7:    return !f[`FLAG_Z];
            4'd8:    return f[`FLAG_O];
            4'd9:    return f[`FLAG_P];
            default: return 1'b0;
        endcase
    endfunction

    task automatic alu_ref(input word_t l, input word_t r, input alu_mode_t m, input logic cin,
                           output word_t res, output flags_t f);
        logic [16:0] s;
        logic        c;
        logic        o;
        int          n;
        int          sv;
        n = int'(r[3:0]);
        c = 1'b0;
        o = 1'b0;
        case (m)
            ALU_ADD, ALU_ADC: begin
                s   = {1'b0, l} + {1'b0, r} + {16'd0, (m == ALU_ADC) & cin};
                res = s[15:0];
                c   = s[16];
                // Overflow when the signed sum leaves the 16-bit range
                sv  = int'($signed(l)) + int'($signed(r)) + (((m == ALU_ADC) && cin) ? 1 : 0);
                o   = (sv > 32767) || (sv < -32768);
            end
            ALU_SUB: begin
                s   = {1'b0, l} - {1'b0, r};
                res = s[15:0];
                c   = s[16];
                sv  = int'($signed(l)) - int'($signed(r));
                o   = (sv > 32767) || (sv < -32768);
            end
            ALU_AND: res = l & r;
            ALU_OR:  res = l | r;
            ALU_XOR: res = l ^ r;
            ALU_SHL: begin
                res = l << n;
                c   = (n == 0) ? 1'b0 : l[16-n];
            end
            ALU_SHR: begin
                res = l >> n;
                c   = (n == 0) ? 1'b0 : l[n-1];
            end
            default: res = '0;
        endcase
        f[`FLAG_C] = c;
        f[`FLAG_Z] = (res == '0);
        f[`FLAG_N] = res[15];
        f[`FLAG_O] = o;
        f[`FLAG_P] = ~^res;
    endtask

    task automatic add_row(input word_t ins, input word_t im, input logic pr);
        t_instr[n_rows] = ins;
        t_imm[n_rows]   = im;
        t_pred[n_rows]  = pr;
        n_rows++;
    endtask

    task automatic build_table();
        reg_idx_t cl;
        reg_idx_t cr;
        add_row(enc_alu(`OP_ALUI, 3'd1, 3'd0, 3'd0, ALU_ADD), 16'($random(seed)), 1'b0);
        add_row(enc_alu(`OP_ALUI, 3'd2, 3'd0, 3'd0, ALU_ADD), 16'($random(seed)), 1'b0);
        // Reads r2 right after it is written
        add_row(enc_alu(`OP_ALU, 3'd3, 3'd1, 3'd2, ALU_ADD), 16'd0, 1'b0);
        add_row(enc_alu(`OP_ALU, 3'd4, 3'd1, 3'd2, ALU_ADC), 16'd0, 1'b0);
        add_row(enc_alu(`OP_ALU, 3'd5, 3'd1, 3'd2, ALU_SUB), 16'd0, 1'b0);
        add_row(enc_alu(`OP_ALU, 3'd6, 3'd1, 3'd2, ALU_AND), 16'd0, 1'b0);
        add_row(enc_alu(`OP_ALU, 3'd7, 3'd1, 3'd2, ALU_OR), 16'd0, 1'b0);
        add_row(enc_alu(`OP_ALU, 3'd3, 3'd1, 3'd2, ALU_XOR), 16'd0, 1'b0);
        add_row(enc_alu(`OP_ALUI, 3'd4, 3'd1, 3'd0, ALU_SHL), 16'd3, 1'b0);
        add_row(enc_alu(`OP_ALUI, 3'd6, 3'd4, 3'd0, ALU_SHR), 16'd5, 1'b0);
        add_row(enc_alu(`OP_ALUI, 3'd7, 3'd1, 3'd0, ALU_ADD), 16'hffff, 1'b0);
        add_row(enc_alu(`OP_ALU, 3'd3, 3'd2, 3'd2, ALU_ADC), 16'd0, 1'b0);
        // r0 write is reported but never stored
        add_row(enc_alu(`OP_ALUI, 3'd0, 3'd0, 3'd0, ALU_ADD), 16'h0055, 1'b0);
        // Lets the r0 write retire before r0 is read
        add_row(enc_alu(`OP_ALUI, 3'd5, 3'd2, 3'd0, ALU_XOR), 16'h00f0, 1'b0);
        add_row(enc_alu(`OP_ALU, 3'd7, 3'd0, 3'd0, ALU_OR), 16'd0, 1'b0);
        for (int k = 0; k < 10; k++) begin
            cl = (k % 3 == 1) ? 3'd2 : 3'd1;
            cr = (k % 3 == 2) ? 3'd1 : 3'd2;
            add_row(enc_alu(`OP_CMP, 3'd0, cl, cr, ALU_SUB), 16'd0, 1'b0);
            add_row(enc_jump((k % 2 == 1) ? 3'd6 : 3'd0, 4'(k)), 16'h0100 + 16'(k * 16),
                    1'($random(seed)));
            // Filler that a flush discards
            add_row(enc_alu(`OP_ALUI, 3'd7, 3'd0, 3'd0, ALU_ADD), 16'(k + 1), 1'b0);
        end
    endtask

    // Reference model of the stage, one row at a time
    task automatic build_expect();
        word_t      mr[`REG_CNT];
        flags_t     mf;
        word_t      mpc;
        logic       flush_pend;
        logic       prev_wr;
        reg_idx_t   prev_reg;
        logic [3:0] op;
        reg_idx_t   d;
        reg_idx_t   l;
        reg_idx_t   r;
        logic       use_l;
        logic       use_r;
        logic       taken;
        word_t      rv;
        word_t      res;
        flags_t     f;
        for (int j = 0; j < `REG_CNT; j++) begin
            mr[j] = '0;
        end
        mf = '0;
        mpc = '0;
        flush_pend = 1'b0;
        prev_wr = 1'b0;
        prev_reg = '0;
        for (int i = 0; i < n_rows; i++) begin
            op = t_instr[i][15:12];
            d = t_instr[i][11:9];
            l = t_instr[i][8:6];
            r = t_instr[i][5:3];
            t_kind[i] = 0;
            t_reg[i] = d;
            t_data[i] = '0;
            t_flush[i] = 1'b0;
            t_hold[i] = 0;
            if (flush_pend) begin
                t_kind[i] = 2;
                t_pc[i] = mpc;
                flush_pend = 1'b0;
                prev_wr = 1'b0;
                continue;
            end
            use_l = op inside {`OP_ALU, `OP_ALUI, `OP_CMP, `OP_JMP};
            use_r = op inside {`OP_ALU, `OP_CMP};
            if (prev_wr && prev_reg != '0 &&
                ((use_l && l == prev_reg) || (use_r && r == prev_reg))) begin
                t_hold[i] = 1;
            end
            prev_wr = 1'b0;
            rv = (op == `OP_ALUI) ? t_imm[i] : mr[r];
            if (op inside {`OP_ALU, `OP_ALUI, `OP_CMP}) begin
                alu_ref(mr[l], rv, (op == `OP_CMP) ? ALU_SUB : alu_mode_t'(t_instr[i][2:0]),
                        mf[`FLAG_C], res, f);
                mf = f;
                if (op != `OP_CMP) begin
                    t_kind[i] = 1;
                    t_data[i] = res;
                    if (d != '0) begin
                        mr[d] = res;
                    end
                    prev_wr = 1'b1;
                    prev_reg = d;
                end
                mpc = mpc + 16'd1;
            end else if (op == `OP_JMP) begin
                taken = cond_ref(t_instr[i][3:0], mf);
                t_flush[i] = (taken != t_pred[i]) || (t_instr[i][3:0] == 4'd0);
                flush_pend = t_flush[i];
                mpc = taken ? mr[l] + t_imm[i] : mpc + 16'd1;
            end else begin
                mpc = mpc + 16'd1;
            end
            t_pc[i] = mpc;
        end
    endtask

    initial begin
        int hold_n;
        rst = 1'b1;
        instr = '0;
        imm = '0;
        submit = 1'b0;
        jmp_predict = 1'b0;
        build_table();
        build_expect();
        for (int i = 0; i < n_rows; i++) begin
            chk.push_expect(t_kind[i], t_reg[i], t_data[i], t_pc[i], t_flush[i], t_hold[i]);
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        chk.check_idle();
        @(posedge clk);
        for (int i = 0; i < n_rows; i++) begin
            instr <= t_instr[i];
            imm <= t_imm[i];
            jmp_predict <= t_pred[i];
            submit <= 1'b1;
            @(negedge clk);
            if (i > 0) begin
                chk.row_done(holds[i-1]);
            end
            hold_n = 0;
            while (!ready) begin
                hold_n++;
                @(negedge clk);
            end
            holds[i] = hold_n;
            @(posedge clk);
        end
        submit <= 1'b0;
        @(negedge clk);
        chk.row_done(holds[n_rows-1]);
        // Write-back count of the last cycle is settled by the next edge
        @(posedge clk);
        chk.final_check();
        $display("Passed: %0d  Failed: %0d", chk.pass_cnt, chk.fail_cnt);
        if (chk.fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // At most four cycles per row plus reset
    initial begin
        wait (n_rows > 0);
        #((n_rows * 4 + 8) * 40);
        $display("Watchdog timeout: the run did not finish in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- tb/exec_core_checker.sv
`include "cpu_macros.svh"

module exec_core_checker import cpu_pkg::*; (
    input  logic     i_clk,
    input  logic     i_flush,
    input  word_t    i_pc,
    input  logic     i_wb_valid,
    input  reg_idx_t i_wb_reg,
    input  word_t    i_wb_data
);

    timeunit 1ns;
    timeprecision 100ps;

    int pass_cnt = 0;
    int fail_cnt = 0;
    int row_num = 0;
    int wb_seen = 0;
    int wb_expected = 0;

    // Expected results, one entry per stimulus row
    int       q_kind[$];
    reg_idx_t q_reg[$];
    word_t    q_data[$];
    word_t    q_pc[$];
    logic     q_flush[$];
    int       q_hold[$];

    // Every write-back the DUT produces, including stray ones
    always @(negedge i_clk) begin
        if (i_wb_valid) begin
            wb_seen++;
        end
    end

    task automatic push_expect(input int kind, input reg_idx_t r, input word_t d,
                               input word_t pc, input logic fl, input int hold);
        q_kind.push_back(kind);
        q_reg.push_back(r);
        q_data.push_back(d);
        q_pc.push_back(pc);
        q_flush.push_back(fl);
        q_hold.push_back(hold);
        if (kind == 1) begin
            wb_expected++;
        end
    endtask

    task automatic check_idle();
        if (i_pc != '0 || i_wb_valid || i_flush) begin
            $display("FAILED %0t reset state: pc=%h wb_valid=%b flush=%b", $time, i_pc,
                     i_wb_valid, i_flush);
            fail_cnt++;
        end else begin
            $display("reset state: ok");
            pass_cnt++;
        end
    endtask

    // Called in the cycle after a row was taken by the DUT
    task automatic row_done(input int holds);
        int       kind;
        reg_idx_t r;
        word_t    d;
        word_t    pc;
        logic     fl;
        int       hold;
        logic     ok;
        kind = q_kind.pop_front();
        r    = q_reg.pop_front();
        d    = q_data.pop_front();
        pc   = q_pc.pop_front();
        fl   = q_flush.pop_front();
        hold = q_hold.pop_front();
        ok   = 1'b1;
        if (kind == 1) begin
            if (!i_wb_valid) begin
                $display("row %0d: expected a write-back but none arrived", row_num);
                ok = 1'b0;
            end else if (i_wb_reg != r || i_wb_data != d) begin
                $display("FAILED %0t row %0d: write-back r%0d=%h, expected r%0d=%h", $time,
                         row_num, i_wb_reg, i_wb_data, r, d);
                ok = 1'b0;
            end
        end else if (i_wb_valid) begin
            $display("row %0d: write-back from an instruction that must not write", row_num);
            ok = 1'b0;
        end
        if (i_pc != pc) begin
            $display("FAILED %0t row %0d: pc=%h, expected %h", $time, row_num, i_pc, pc);
            ok = 1'b0;
        end
        if (i_flush != fl) begin
            $display("FAILED %0t row %0d: flush=%b, expected %b", $time, row_num, i_flush, fl);
            ok = 1'b0;
        end
        if (holds != hold) begin
            $display("FAILED %0t row %0d: ready low for %0d cycles, expected %0d", $time,
                     row_num, holds, hold);
            ok = 1'b0;
        end
        if (ok) begin
            $display("row %0d: ok", row_num);
            pass_cnt++;
        end else begin
            $display("row %0d: failed", row_num);
            fail_cnt++;
        end
        row_num++;
    endtask

    task automatic final_check();
        if (wb_seen != wb_expected) begin
            $display("The DUT produced %0d write-backs where %0d were expected", wb_seen,
                     wb_expected);
            fail_cnt++;
        end
    endtask

endmodule

//--- source/exec_core.sv
`include "cpu_macros.svh"

module exec_core import cpu_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  word_t    i_instr,
    input  word_t    i_imm,
    input  logic     i_submit,
    input  logic     i_jmp_predict,
    output logic     o_ready,
    output logic     o_flush,
    output word_t    o_pc,
    output logic     o_wb_valid,
    output reg_idx_t o_wb_reg,
    output word_t    o_wb_data
);

    // Decoder fields
    reg_idx_t   c_l_sel;
    reg_idx_t   c_r_sel;
    reg_idx_t   c_wr_sel;
    logic       c_r_imm;
    logic       c_wr_en;
    logic       c_flags_ie;
    logic       c_carry_en;
    alu_mode_t  c_alu_mode;
    jump_code_t c_jump_code;
    logic [1:0] c_used_operands;

    // Datapath
    word_t  rf_l;
    word_t  rf_r;
    word_t  alu_r;
    word_t  alu_out;
    flags_t alu_flags;
    logic   alu_carry;

    instr_decode u_decode (
        .i_instr         (i_instr),
        .o_l_sel         (c_l_sel),
        .o_r_sel         (c_r_sel),
        .o_wr_sel        (c_wr_sel),
        .o_r_imm         (c_r_imm),
        .o_wr_en         (c_wr_en),
        .o_flags_ie      (c_flags_ie),
        .o_carry_en      (c_carry_en),
        .o_alu_mode      (c_alu_mode),
        .o_jump_code     (c_jump_code),
        .o_used_operands (c_used_operands)
    );

    // Write port fed from the execute output register
    reg_file u_rf (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_l_sel   (c_l_sel),
        .i_r_sel   (c_r_sel),
        .i_wr_sel  (o_wb_reg),
        .i_wr_en   (o_wb_valid),
        .i_wr_data (o_wb_data),
        .o_l       (rf_l),
        .o_r       (rf_r)
    );

    alu u_alu (
        .i_l     (rf_l),
        .i_r     (alu_r),
        .i_mode  (c_alu_mode),
        .i_carry (alu_carry),
        .o_out   (alu_out),
        .o_flags (alu_flags)
    );

    execute u_exec (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_submit        (i_submit),
        .i_imm           (i_imm),
        .i_jmp_predict   (i_jmp_predict),
        .c_l_sel         (c_l_sel),
        .c_r_sel         (c_r_sel),
        .c_r_imm         (c_r_imm),
        .c_carry_en      (c_carry_en),
        .c_flags_ie      (c_flags_ie),
        .c_wr_en         (c_wr_en),
        .c_wr_sel        (c_wr_sel),
        .c_jump_code     (c_jump_code),
        .c_used_operands (c_used_operands),
        .i_l_data        (rf_l),
        .i_r_data        (rf_r),
        .i_alu_out       (alu_out),
        .i_alu_flags     (alu_flags),
        .o_alu_r         (alu_r),
        .o_alu_carry     (alu_carry),
        .o_ready         (o_ready),
        .o_flush         (o_flush),
        .o_pc            (o_pc),
        .o_wb_valid      (o_wb_valid),
        .o_wb_reg        (o_wb_reg),
        .o_wb_data       (o_wb_data)
    );

endmodule

//--- source/execute.sv
`include "cpu_macros.svh"

module execute import cpu_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_submit,
    input  word_t      i_imm,
    input  logic       i_jmp_predict,
    input  reg_idx_t   c_l_sel,
    input  reg_idx_t   c_r_sel,
    input  logic       c_r_imm,
    input  logic       c_carry_en,
    input  logic       c_flags_ie,
    input  logic       c_wr_en,
    input  reg_idx_t   c_wr_sel,
    input  jump_code_t c_jump_code,
    input  logic [1:0] c_used_operands,
    input  word_t      i_l_data,
    input  word_t      i_r_data,
    input  word_t      i_alu_out,
    input  flags_t     i_alu_flags,
    output word_t      o_alu_r,
    output logic       o_alu_carry,
    output logic       o_ready,
    output logic       o_flush,
    output word_t      o_pc,
    output logic       o_wb_valid,
    output reg_idx_t   o_wb_reg,
    output word_t      o_wb_data
);

    flags_t flags_q;
    logic   raw_hazard;
    logic   instr_valid;
    logic   exec_accept;
    logic   jump_valid;
    logic   jump_taken;
    logic   jump_flush;
    word_t  jump_target;

    // RAW against the result still waiting in the output register
    // The register file holds the new value one cycle later, r0 never conflicts
    assign raw_hazard = o_wb_valid && (o_wb_reg != '0) &&
        ((c_used_operands[0] && (c_l_sel == o_wb_reg)) ||
         (c_used_operands[1] && (c_r_sel == o_wb_reg)));

    // Instruction presented during flush is dropped
    assign instr_valid = i_submit & ~o_flush;
    assign exec_accept = instr_valid & ~raw_hazard;

    // Hold the fetch side only for a real instruction
    assign o_ready = ~(instr_valid & raw_hazard);

    assign o_alu_r     = c_r_imm ? i_imm : i_r_data;
    assign o_alu_carry = flags_q[`FLAG_C] & c_carry_en;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            flags_q <= '0;
        end else if (exec_accept && c_flags_ie) begin
            flags_q <= i_alu_flags;
        end
    end

    // Jump condition from the stored flags
    assign jump_valid = c_jump_code[`JUMP_CODE_BIT_EN];

    always_comb begin
        case (c_jump_code)
            `JUMP_CODE_UNCOND: jump_taken = 1'b1;
            `JUMP_CODE_CARRY:  jump_taken = flags_q[`FLAG_C];
            `JUMP_CODE_EQUAL:  jump_taken = flags_q[`FLAG_Z];
            `JUMP_CODE_LT:     jump_taken = flags_q[`FLAG_N];
            `JUMP_CODE_GT:     jump_taken = ~(flags_q[`FLAG_N] | flags_q[`FLAG_Z]);
            `JUMP_CODE_LE:     jump_taken = flags_q[`FLAG_N] | flags_q[`FLAG_Z];
            `JUMP_CODE_GE:     jump_taken = ~flags_q[`FLAG_N];
            `JUMP_CODE_NE:     jump_taken = ~flags_q[`FLAG_Z];
            `JUMP_CODE_OVF:    jump_taken = flags_q[`FLAG_O];
            `JUMP_CODE_PAR:    jump_taken = flags_q[`FLAG_P];
            default:           jump_taken = 1'b0;
        endcase
    end

    // Base register plus offset, ALU stays free
    assign jump_target = i_l_data + i_imm;

    // Wrong prediction, or an unconditional jump redirecting fetch
    assign jump_flush = jump_valid &&
        ((jump_taken ^ i_jmp_predict) || (c_jump_code == `JUMP_CODE_UNCOND));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_flush <= 1'b0;
        end else begin
            o_flush <= exec_accept & jump_flush;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc <= '0;
        end else if (exec_accept) begin
            if (jump_valid && jump_taken) begin
                o_pc <= jump_target;
            end else begin
                o_pc <= o_pc + `RW'd1;
            end
        end
    end

    // Write-back register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= exec_accept & c_wr_en;
        end
    end

    always_ff @(posedge i_clk) begin
        if (exec_accept && c_wr_en) begin
            o_wb_reg  <= c_wr_sel;
            o_wb_data <= i_alu_out;
        end
    end

    // A held instruction stays on the fetch inputs until it is accepted
    a_hold_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        !o_ready |=> i_submit && $stable(i_imm) && $stable(c_wr_sel) &&
            $stable(c_l_sel) && $stable(c_r_sel))
        else $error("execute: fetch side changed a held instruction");

    a_wb_known: assert property (@(posedge i_clk) disable iff (i_rst)
        o_wb_valid |-> !$isunknown(o_wb_reg) && !$isunknown(o_wb_data))
        else $error("execute: write-back with unknown register or data");

endmodule

//--- source/reg_file.sv
`include "cpu_macros.svh"

module reg_file import cpu_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  reg_idx_t i_l_sel,
    input  reg_idx_t i_r_sel,
    input  reg_idx_t i_wr_sel,
    input  logic     i_wr_en,
    input  word_t    i_wr_data,
    output word_t    o_l,
    output word_t    o_r
);

    word_t regs [`REG_CNT];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_sel != '0)) begin
            // Register 0 is never written
            regs[i_wr_sel] <= i_wr_data;
        end
    end

    // Two asynchronous read ports, r0 is constant zero
    assign o_l = (i_l_sel == '0) ? '0 : regs[i_l_sel];
    assign o_r = (i_r_sel == '0) ? '0 : regs[i_r_sel];

endmodule

//--- source/alu.sv
`include "cpu_macros.svh"

module alu import cpu_pkg::*; (
    input  word_t     i_l,
    input  word_t     i_r,
    input  alu_mode_t i_mode,
    input  logic      i_carry,
    output word_t     o_out,
    output flags_t    o_flags
);

    // Result with carry or borrow in the top bit
    logic [`RW:0] wide;
    logic [`RW:0] shr;
    logic         ovf;

    // Bit shifted out on the right lands in shr[0]
    assign shr = {i_l, 1'b0} >> i_r[3:0];

    always_comb begin
        wide = '0;
        ovf  = 1'b0;
        case (i_mode)
            ALU_ADD: begin
                wide = {1'b0, i_l} + {1'b0, i_r};
                ovf  = (i_l[`RW-1] == i_r[`RW-1]) && (wide[`RW-1] != i_l[`RW-1]);
            end
            ALU_ADC: begin
                wide = {1'b0, i_l} + {1'b0, i_r} + {{`RW{1'b0}}, i_carry};
                ovf  = (i_l[`RW-1] == i_r[`RW-1]) && (wide[`RW-1] != i_l[`RW-1]);
            end
            ALU_SUB: begin
                // Top bit is the borrow
                wide = {1'b0, i_l} - {1'b0, i_r};
                ovf  = (i_l[`RW-1] != i_r[`RW-1]) && (wide[`RW-1] != i_l[`RW-1]);
            end
            ALU_AND: wide = {1'b0, i_l & i_r};
            ALU_OR:  wide = {1'b0, i_l | i_r};
            ALU_XOR: wide = {1'b0, i_l ^ i_r};
            ALU_SHL: wide = {1'b0, i_l} << i_r[3:0];
            ALU_SHR: wide = {shr[0], shr[`RW:1]};
            default: wide = '0;
        endcase
    end

    assign o_out = wide[`RW-1:0];

    assign o_flags[`FLAG_C] = wide[`RW];
    assign o_flags[`FLAG_Z] = (o_out == '0);
    assign o_flags[`FLAG_N] = o_out[`RW-1];
    assign o_flags[`FLAG_O] = ovf;
    // Set when the count of ones is even
    assign o_flags[`FLAG_P] = ~^o_out;

    // Decoder output must always resolve to a legal mode
    always_comb begin
        assert (!$isunknown(i_mode))
            else $error("alu: unknown mode on i_mode");
    end

endmodule

//--- source/instr_decode.sv
`include "cpu_macros.svh"

module instr_decode import cpu_pkg::*; (
    input  word_t      i_instr,
    output reg_idx_t   o_l_sel,
    output reg_idx_t   o_r_sel,
    output reg_idx_t   o_wr_sel,
    output logic       o_r_imm,
    output logic       o_wr_en,
    output logic       o_flags_ie,
    output logic       o_carry_en,
    output alu_mode_t  o_alu_mode,
    output jump_code_t o_jump_code,
    output logic [1:0] o_used_operands
);

    // Layout: op[15:12] dst[11:9] left[8:6] right[5:3] mode[2:0]
    opcode_t   op;
    alu_mode_t mode;

    assign op   = i_instr[15:12];
    assign mode = alu_mode_t'(i_instr[2:0]);

    always_comb begin
        o_l_sel         = i_instr[8:6];
        o_r_sel         = i_instr[5:3];
        o_wr_sel        = i_instr[11:9];
        // Nothing enabled unless the opcode says so
        o_r_imm         = 1'b0;
        o_wr_en         = 1'b0;
        o_flags_ie      = 1'b0;
        o_alu_mode      = ALU_ADD;
        o_jump_code     = '0;
        o_used_operands = 2'b00;

        case (op)
            `OP_ALU: begin
                o_alu_mode      = mode;
                o_wr_en         = 1'b1;
                o_flags_ie      = 1'b1;
                o_used_operands = 2'b11;
            end
            `OP_ALUI: begin
                // Right operand from i_imm
                o_alu_mode      = mode;
                o_r_imm         = 1'b1;
                o_wr_en         = 1'b1;
                o_flags_ie      = 1'b1;
                o_used_operands = 2'b01;
            end
            `OP_CMP: begin
                // Subtract for flags only
                o_alu_mode      = ALU_SUB;
                o_flags_ie      = 1'b1;
                o_used_operands = 2'b11;
            end
            `OP_JMP: begin
                // Condition in instr[3:0], left register is the target base
                o_jump_code     = {1'b1, i_instr[3:0]};
                o_used_operands = 2'b01;
            end
            default: begin
                o_used_operands = 2'b00;
            end
        endcase
    end

    // Only ADC consumes the stored carry
    assign o_carry_en = (o_alu_mode == ALU_ADC);

endmodule

//--- source/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

    // Data word and register index
    typedef logic [`RW-1:0] word_t;
    typedef logic [`REG_LOG-1:0] reg_idx_t;

    // Flag vector, bit positions from the FLAG_ macros
    typedef logic [`FLAG_CNT-1:0] flags_t;

    // Enable bit on top of a 4-bit condition
    typedef logic [`JUMP_CODE_W-1:0] jump_code_t;

    typedef logic [`OP_W-1:0] opcode_t;

    // Mode field of ALU instructions, instr[2:0]
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_ADC = 3'd1,
        ALU_SUB = 3'd2,
        ALU_AND = 3'd3,
        ALU_OR  = 3'd4,
        ALU_XOR = 3'd5,
        ALU_SHL = 3'd6,
        ALU_SHR = 3'd7
    } alu_mode_t;

endpackage

//--- source/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath and register file sizes
`define RW       16
`define REG_CNT  8
`define REG_LOG  3

// ALU flags and their bit positions
`define FLAG_CNT 5
`define FLAG_C   0
`define FLAG_Z   1
`define FLAG_N   2
`define FLAG_O   3
`define FLAG_P   4

// Opcode field, instr[15:12]
`define OP_W     4
`define OP_NOP   4'h0
`define OP_ALU   4'h1
`define OP_ALUI  4'h2
`define OP_CMP   4'h3
`define OP_JMP   4'h4

// Jump codes, the top bit marks a jump
`define JUMP_CODE_W      5
`define JUMP_CODE_BIT_EN 4
`define JUMP_CODE_UNCOND 5'b10000
`define JUMP_CODE_CARRY  5'b10001
`define JUMP_CODE_EQUAL  5'b10010
`define JUMP_CODE_LT     5'b10011
`define JUMP_CODE_GT     5'b10100
`define JUMP_CODE_LE     5'b10101
`define JUMP_CODE_GE     5'b10110
`define JUMP_CODE_NE     5'b10111
`define JUMP_CODE_OVF    5'b11000
`define JUMP_CODE_PAR    5'b11001

`endif
